//--- rtl/cpu_pkg.sv
// shared types, opcodes and stage payloads of the five-stage mips core, imported by the rtl
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t RESET_PC = 32'hBFC0_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE, BR_BEQ, BR_BNE
    } branch_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_a_shamt;  // port a takes the shift amount
        logic    src_b_imm;    // port b takes the immediate
        logic    read_rs;
        logic    read_rt;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    link;         // writes pc+8
        branch_e branch;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t      pc;
        ctrl_t      ctrl;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   dst;
        word_t      bus_a;
        word_t      bus_b;
        word_t      imm;
        logic [4:0] shamt;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t dst;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    result;      // alu result, or pc+8 for a link
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t dst;
        logic     reg_write;
        word_t    result;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- rtl/stage_reg.sv
// pipeline register between two core stages, with stall hold and bubble flush
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload is a bubble in every stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
// decode-stage instruction decoder producing control bits, register fields and the immediate
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import cpu_pkg::*; (
    input  word_t       instr_i,
    output ctrl_t       ctrl_o,
    output reg_idx_t    rs_o,
    output reg_idx_t    rt_o,
    output reg_idx_t    dst_o,
    output word_t       imm_o,
    output logic [4:0]  shamt_o,
    output logic [25:0] jump_target_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        sign_ext;
    ctrl_t       ctrl;
    reg_idx_t    dst;

    assign opcode        = instr_i[31:26];
    assign funct         = instr_i[5:0];
    assign imm16         = instr_i[15:0];
    assign rs_o          = instr_i[25:21];
    assign rt_o          = instr_i[20:16];
    assign shamt_o       = instr_i[10:6];
    assign jump_target_o = instr_i[25:0];

    always_comb begin
        ctrl     = '0;
        dst      = rt_o;   // i-type default
        sign_ext = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                dst            = instr_i[15:11];
                ctrl.read_rs   = 1'b1;
                ctrl.read_rt   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        ctrl.alu_op      = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        ctrl.src_a_shamt = 1'b1;
                        ctrl.read_rs     = 1'b0;
                    end
                    default: ctrl = '0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                ctrl.src_b_imm = 1'b1;
                ctrl.read_rs   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = (opcode == OP_LW);
            end
            OP_ANDI, OP_ORI: begin
                sign_ext       = 1'b0;
                ctrl.alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                ctrl.src_b_imm = 1'b1;
                ctrl.read_rs   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LUI: begin
                sign_ext       = 1'b0;
                ctrl.alu_op    = ALU_LUI;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_SW: begin
                ctrl.src_b_imm = 1'b1;  // address is rs + offset
                ctrl.read_rs   = 1'b1;
                ctrl.read_rt   = 1'b1;  // store data
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.read_rs = 1'b1;
                ctrl.read_rt = 1'b1;
                ctrl.branch  = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_J: ctrl.jump = 1'b1;
            OP_JAL: begin
                dst            = 5'd31;
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = '0;
        endcase
        if (dst == '0) begin
            ctrl.reg_write = 1'b0;  // r0 is never written
        end
    end

    assign ctrl_o = ctrl;
    assign dst_o  = dst;
    assign imm_o  = sign_ext ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// general register file read in decode and written from writeback, with same-cycle bypass
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i,
    input  reg_idx_t raddr_a_i,
    input  reg_idx_t raddr_b_i,
    output word_t    rdata_a_o,
    output word_t    rdata_b_o
);

    word_t regs_q [1:31];  // r0 is hardwired

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    function automatic word_t read_port(reg_idx_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (we_i && addr == waddr_i) begin
            value = wdata_i;  // writeback bypass
        end else begin
            value = regs_q[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
// forwarding selects, load-use stall and branch fetch kill for the core pipeline
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs_i,
    input  reg_idx_t id_rt_i,
    input  ctrl_t    id_ctrl_i,
    input  id_ex_t   ex_i,
    input  ex_mem_t  mem_i,
    input  mem_wb_t  wb_i,
    input  logic     branch_taken_i,
    output fwd_sel_e fwd_a_o,
    output fwd_sel_e fwd_b_o,
    output logic     hold_front_o,
    output logic     flush_ex_o,
    output logic     kill_id_o
);

    logic load_use;

    // youngest writer wins, memory stage before writeback
    function automatic fwd_sel_e pick_source(reg_idx_t src, ex_mem_t mem, mem_wb_t wb);
        fwd_sel_e sel;
        if (src == '0) begin
            sel = FWD_REG;
        end else if (mem.reg_write && mem.dst == src) begin
            sel = FWD_MEM;
        end else if (wb.reg_write && wb.dst == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_source(ex_i.rs, mem_i, wb_i);
    assign fwd_b_o = pick_source(ex_i.rt, mem_i, wb_i);

    // load data only arrives in its memory stage
    assign load_use = ex_i.ctrl.mem_read && ex_i.ctrl.reg_write &&
                      ((id_ctrl_i.read_rs && id_rs_i == ex_i.dst) ||
                       (id_ctrl_i.read_rt && id_rt_i == ex_i.dst));

    assign hold_front_o = load_use;
    assign flush_ex_o   = load_use;        // bubble into execute
    assign kill_id_o    = branch_taken_i;  // fetch behind the delay slot

endmodule

`default_nettype wire

//--- rtl/alu.sv
// execute-stage arithmetic, logic and shift unit with the beq/bne compare
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    input  branch_e branch_i,
    input  word_t   cmp_a_i,
    input  word_t   cmp_b_i,
    output word_t   result_o,
    output logic    taken_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = b_i << a_i[4:0];  // a is the shift amount
            ALU_SRL: result_o = b_i >> a_i[4:0];
            ALU_LUI: result_o = {b_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

    // compare uses forwarded registers, not the immediate mux
    always_comb begin
        case (branch_i)
            BR_BEQ:  taken_o = (cmp_a_i == cmp_b_i);
            BR_BNE:  taken_o = (cmp_a_i != cmp_b_i);
            default: taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mycpu_top.sv
// five-stage mips32 core top with instruction and data sram ports and the writeback trace
`timescale 1ns/1ps
`default_nettype none

module mycpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    output logic       inst_sram_en_o,
    output word_t      inst_sram_addr_o,
    input  word_t      inst_sram_rdata_i,
    output logic       data_sram_en_o,
    output logic [3:0] data_sram_wen_o,
    output word_t      data_sram_addr_o,
    output word_t      data_sram_wdata_o,
    input  word_t      data_sram_rdata_i,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_idx_t   debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    word_t       pc_q;
    word_t       next_pc;
    logic        fetch_valid_q;
    if_id_t      if_d;
    if_id_t      id_q;
    id_ex_t      id_d;
    id_ex_t      ex_q;
    ex_mem_t     ex_d;
    ex_mem_t     mem_q;
    mem_wb_t     mem_d;
    mem_wb_t     wb_q;
    ctrl_t       id_ctrl;
    reg_idx_t    id_rs;
    reg_idx_t    id_rt;
    reg_idx_t    id_dst;
    word_t       id_imm;
    word_t       id_bus_a;
    word_t       id_bus_b;
    logic [4:0]  id_shamt;
    logic [25:0] id_jump_index;
    word_t       jump_target;
    word_t       branch_target;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    word_t       ex_op_a;
    word_t       ex_op_b;
    word_t       alu_a;
    word_t       alu_b;
    word_t       alu_result;
    logic        branch_taken;
    logic        hold_front;
    logic        flush_ex;
    logic        kill_id;
    word_t       mem_result;

    // fetch
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= RESET_PC - 32'd4;  // first advance lands on RESET_PC
            fetch_valid_q <= 1'b0;
        end else if (!hold_front) begin
            pc_q          <= next_pc;
            fetch_valid_q <= 1'b1;
        end
    end

    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;
        end else if (id_ctrl.jump) begin
            next_pc = jump_target;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    assign inst_sram_en_o   = arst_n_i && !hold_front;  // sram keeps its word while stalled
    assign inst_sram_addr_o = next_pc;
    assign if_d = fetch_valid_q ? if_id_t'{pc_q, inst_sram_rdata_i} : if_id_t'('0);

    stage_reg #(.payload_t(if_id_t)) stage_if_id_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (hold_front),
        .flush_i  (kill_id),
        .d_i      (if_d),
        .q_o      (id_q)
    );

    // decode
    inst_decoder inst_decoder_i (
        .instr_i       (id_q.instr),
        .ctrl_o        (id_ctrl),
        .rs_o          (id_rs),
        .rt_o          (id_rt),
        .dst_o         (id_dst),
        .imm_o         (id_imm),
        .shamt_o       (id_shamt),
        .jump_target_o (id_jump_index)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .we_i      (wb_q.reg_write),
        .waddr_i   (wb_q.dst),
        .wdata_i   (wb_q.result),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .rdata_a_o (id_bus_a),
        .rdata_b_o (id_bus_b)
    );

    // pc_q is the delay slot while a jump decodes
    assign jump_target = {pc_q[31:28], id_jump_index, 2'b00};

    assign id_d = '{pc: id_q.pc, ctrl: id_ctrl, rs: id_rs, rt: id_rt, dst: id_dst,
                    bus_a: id_bus_a, bus_b: id_bus_b, imm: id_imm, shamt: id_shamt};

    stage_reg #(.payload_t(id_ex_t)) stage_id_ex_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (flush_ex),
        .d_i      (id_d),
        .q_o      (ex_q)
    );

    hazard_unit hazard_unit_i (
        .id_rs_i        (id_rs),
        .id_rt_i        (id_rt),
        .id_ctrl_i      (id_ctrl),
        .ex_i           (ex_q),
        .mem_i          (mem_q),
        .wb_i           (wb_q),
        .branch_taken_i (branch_taken),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .hold_front_o   (hold_front),
        .flush_ex_o     (flush_ex),
        .kill_id_o      (kill_id)
    );

    // execute
    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        word_t value;
        case (sel)
            FWD_MEM: value = mem_val;
            FWD_WB:  value = wb_val;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    assign ex_op_a = fwd_mux(fwd_a, ex_q.bus_a, mem_result, wb_q.result);
    assign ex_op_b = fwd_mux(fwd_b, ex_q.bus_b, mem_result, wb_q.result);
    assign alu_a   = ex_q.ctrl.src_a_shamt ? {27'b0, ex_q.shamt} : ex_op_a;
    assign alu_b   = ex_q.ctrl.src_b_imm ? ex_q.imm : ex_op_b;
    assign branch_target = ex_q.pc + 32'd4 + {ex_q.imm[29:0], 2'b00};

    alu alu_i (
        .op_i     (ex_q.ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .branch_i (ex_q.ctrl.branch),
        .cmp_a_i  (ex_op_a),
        .cmp_b_i  (ex_op_b),
        .result_o (alu_result),
        .taken_o  (branch_taken)
    );

    assign ex_d = '{pc: ex_q.pc, dst: ex_q.dst, reg_write: ex_q.ctrl.reg_write,
                    mem_read: ex_q.ctrl.mem_read, mem_write: ex_q.ctrl.mem_write,
                    result: ex_q.ctrl.link ? ex_q.pc + 32'd8 : alu_result,
                    store_data: ex_op_b};

    // sram samples these at the edge into memory
    assign data_sram_en_o    = ex_q.ctrl.mem_read | ex_q.ctrl.mem_write;
    assign data_sram_wen_o   = {4{ex_q.ctrl.mem_write}};  // word stores only
    assign data_sram_addr_o  = alu_result;
    assign data_sram_wdata_o = ex_d.store_data;

    stage_reg #(.payload_t(ex_mem_t)) stage_ex_mem_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .d_i      (ex_d),
        .q_o      (mem_q)
    );

    // memory
    assign mem_result = mem_q.mem_read ? data_sram_rdata_i : mem_q.result;
    assign mem_d = '{pc: mem_q.pc, dst: mem_q.dst, reg_write: mem_q.reg_write,
                     result: mem_result};

    stage_reg #(.payload_t(mem_wb_t)) stage_mem_wb_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .d_i      (mem_d),
        .q_o      (wb_q)
    );

    // writeback trace
    assign debug_wb_pc_o       = wb_q.pc;
    assign debug_wb_rf_wen_o   = {4{wb_q.reg_write}};  // r0 writes already dropped
    assign debug_wb_rf_wnum_o  = wb_q.dst;
    assign debug_wb_rf_wdata_o = wb_q.result;

endmodule

`default_nettype wire

//--- testbench/tb_model.svh
// random program generator and instruction-level reference model, included inside tb_top
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    word_t    pc;
    logic     we;
    reg_idx_t num;
    word_t    data;
} retire_t;

typedef struct packed {
    word_t addr;
    word_t data;
} store_t;

retire_t     exp_trace [$];   // one entry per retired instruction
store_t      exp_stores [$];
logic [31:0] lfsr_state;

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < width; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        value      = {value[30:0], fb};
    end
    return value;
endfunction

function automatic reg_idx_t pick_reg();
    logic [2:0] r;
    r = 3'(random_bits(3));
    return (r == 3'd0) ? reg_idx_t'(7) : reg_idx_t'(r);  // r1..r7 only
endfunction

function automatic word_t fill_word(input int index);
    return (word_t'(index) * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
endfunction

function automatic word_t random_plain_instr();
    logic [3:0]  kind;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [15:0] imm;
    logic [5:0]  fn;
    word_t       instr;
    kind = 4'(random_bits(4));
    rs   = pick_reg();
    rt   = pick_reg();
    rd   = pick_reg();
    imm  = 16'(random_bits(16));
    case (kind[2:0])
        3'd0: fn = FN_ADDU;
        3'd1: fn = FN_SUBU;
        3'd2: fn = FN_AND;
        3'd3: fn = FN_OR;
        3'd4: fn = FN_XOR;
        3'd5: fn = FN_SLT;
        3'd6: fn = FN_SLL;
        3'd7: fn = FN_SRL;
    endcase
    case (kind)
        4'd8:         instr = {OP_ADDIU, rs, rt, imm};
        4'd9:         instr = {OP_ANDI, rs, rt, imm};
        4'd10:        instr = {OP_ORI, rs, rt, imm};
        4'd11:        instr = {OP_LUI, 5'd0, rt, imm};
        4'd12, 4'd13: instr = {OP_LW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};  // 64-word area
        4'd14, 4'd15: instr = {OP_SW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
        default: begin
            if (fn == FN_SLL || fn == FN_SRL) begin
                instr = {OP_SPECIAL, 5'd0, rt, rd, imm[10:6], fn};
            end else begin
                instr = {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
            end
        end
    endcase
    return instr;
endfunction

// forward target 2..9 words past the control instruction
function automatic word_t random_control_instr(input int index);
    logic [1:0] kind;
    reg_idx_t   rs;
    reg_idx_t   rt;
    logic [2:0] hop;
    word_t      target;
    word_t      instr;
    kind   = 2'(random_bits(2));
    rs     = pick_reg();
    rt     = pick_reg();
    hop    = 3'(random_bits(3));
    target = RESET_PC + word_t'((index + 2 + int'(hop)) * 4);
    case (kind)
        2'd0:    instr = {OP_BEQ, rs, rt, 16'(hop) + 16'd1};
        2'd1:    instr = {OP_BNE, rs, rt, 16'(hop) + 16'd1};
        2'd2:    instr = {OP_J, target[27:2]};
        default: instr = {OP_JAL, target[27:2]};
    endcase
    return instr;
endfunction

task automatic generate_program();
    int    i;
    word_t last_addr;
    lfsr_state = LFSR_SEED;
    i          = 0;
    while (i < PROG_LEN - 2) begin
        if (i <= PROG_LEN - 12 && random_bits(2) == 0) begin
            imem[i]     = random_control_instr(i);
            imem[i + 1] = random_plain_instr();  // delay slot
            i += 2;
        end else begin
            imem[i] = random_plain_instr();
            i += 1;
        end
    end
    last_addr          = RESET_PC + word_t'((PROG_LEN - 2) * 4);
    imem[PROG_LEN - 2] = {OP_J, last_addr[27:2]};  // jump to self
    imem[PROG_LEN - 1] = '0;
endtask

task automatic run_model();
    word_t    regs [32];
    word_t    dmem_model [DATA_WORDS];
    word_t    pc;
    word_t    npc;
    word_t    target;
    word_t    instr;
    word_t    a;
    word_t    b;
    word_t    simm;
    word_t    value;
    word_t    addr;
    reg_idx_t dst;
    logic     we;
    logic     finished;
    int       idx;
    for (int k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    for (int k = 0; k < DATA_WORDS; k++) begin
        dmem_model[k] = fill_word(k);
    end
    pc       = RESET_PC;
    npc      = RESET_PC + 32'd4;
    finished = 1'b0;
    while (!finished) begin
        idx    = int'((pc - RESET_PC) >> 2);
        instr  = imem[idx];
        a      = regs[instr[25:21]];
        b      = regs[instr[20:16]];
        simm   = {{16{instr[15]}}, instr[15:0]};
        target = npc + 32'd4;
        dst    = instr[20:16];
        we     = 1'b1;
        value  = '0;
        addr   = a + simm;
        case (instr[31:26])
            OP_SPECIAL: begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_ADDU: value = a + b;
                    FN_SUBU: value = a - b;
                    FN_AND:  value = a & b;
                    FN_OR:   value = a | b;
                    FN_XOR:  value = a ^ b;
                    FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  value = b << instr[10:6];
                    FN_SRL:  value = b >> instr[10:6];
                    default: we = 1'b0;
                endcase
            end
            OP_ADDIU: value = a + simm;
            OP_ANDI:  value = a & {16'b0, instr[15:0]};
            OP_ORI:   value = a | {16'b0, instr[15:0]};
            OP_LUI:   value = {instr[15:0], 16'b0};
            OP_LW:    value = dmem_model[addr[7:2]];
            OP_SW: begin
                we                     = 1'b0;
                dmem_model[addr[7:2]] = b;
                exp_stores.push_back(store_t'{addr, b});
            end
            OP_BEQ: begin
                we = 1'b0;
                if (a == b) begin
                    target = npc + (simm << 2);
                end
            end
            OP_BNE: begin
                we = 1'b0;
                if (a != b) begin
                    target = npc + (simm << 2);
                end
            end
            OP_J: begin
                we     = 1'b0;
                target = {npc[31:28], instr[25:0], 2'b00};
            end
            OP_JAL: begin
                dst    = 5'd31;
                value  = pc + 32'd8;  // return past the delay slot
                target = {npc[31:28], instr[25:0], 2'b00};
            end
            default: we = 1'b0;
        endcase
        if (dst == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            regs[dst] = value;
        end
        exp_trace.push_back(retire_t'{pc, we, we ? dst : 5'd0, we ? value : 32'd0});
        finished = (idx == PROG_LEN - 1);  // delay slot of the final jump
        pc       = npc;
        npc      = target;
    end
endtask

`endif

//--- testbench/tb_top.sv
// testbench for mycpu_top: sram models, a random program, and trace and store checks vs the model
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpu_pkg::*; ();

    localparam int          CLK_PERIOD     = 100;
    localparam int          RESET_CYCLES   = 16;
    localparam int          PROG_LEN       = 400;
    localparam int          DATA_WORDS     = 64;
    localparam int          TIMEOUT_CYCLES = 20 * PROG_LEN;
    localparam logic [31:0] LFSR_SEED      = 32'd41;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t imem [PROG_LEN];
    word_t dmem [DATA_WORDS];
    word_t inst_addr_q;
    word_t data_addr_q;
    int    wb_errors;
    int    store_errors;
    int    other_errors;
    logic  trace_done;
    logic  fetch_seen;

    `include "tb_model.svh"

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    mycpu_top mycpu_top_i (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .inst_sram_en_o      (inst_sram_en),
        .inst_sram_addr_o    (inst_sram_addr),
        .inst_sram_rdata_i   (inst_sram_rdata),
        .data_sram_en_o      (data_sram_en),
        .data_sram_wen_o     (data_sram_wen),
        .data_sram_addr_o    (data_sram_addr),
        .data_sram_wdata_o   (data_sram_wdata),
        .data_sram_rdata_i   (data_sram_rdata),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = (addr - RESET_PC) >> 2;
        return (offset < PROG_LEN) ? imem[offset] : 32'd0;
    endfunction

    // requests are taken at the rising edge
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_addr_q <= inst_sram_addr;
        end
        if (data_sram_en) begin
            data_addr_q <= data_sram_addr;
            if (data_sram_wen != 4'b0) begin
                dmem[data_sram_addr[7:2]] <= data_sram_wdata;
            end
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= fetch_word(inst_addr_q);  // valid one clock after the request
        data_sram_rdata <= dmem[data_addr_q[7:2]];
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, expected);
    endtask

    task automatic check_wb(input word_t pc, input logic [3:0] wen, input reg_idx_t num,
                            input word_t data);
        retire_t exp;
        exp = exp_trace.pop_front();
        if (pc !== exp.pc) begin
            wb_errors++;
            report_mismatch("debug_wb_pc_o", pc, exp.pc);
        end
        if (wen !== {4{exp.we}}) begin
            wb_errors++;
            report_mismatch("debug_wb_rf_wen_o", word_t'(wen), word_t'({4{exp.we}}));
        end else if (exp.we && (num !== exp.num || data !== exp.data)) begin
            wb_errors++;
            report_mismatch("debug_wb_rf_wnum_o", word_t'(num), word_t'(exp.num));
            report_mismatch("debug_wb_rf_wdata_o", data, exp.data);
        end
        if (exp_trace.size() == 0) begin
            trace_done = 1'b1;
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data, input logic [3:0] wen);
        store_t exp;
        if (exp_stores.size() == 0) begin
            store_errors++;
            $display("t=%0t: data sram write to %h with no store left in the model", $time, addr);
        end else begin
            exp = exp_stores.pop_front();
            if (addr !== exp.addr) begin
                store_errors++;
                report_mismatch("data_sram_addr_o", addr, exp.addr);
            end
            if (data !== exp.data) begin
                store_errors++;
                report_mismatch("data_sram_wdata_o", data, exp.data);
            end
            if (wen !== 4'hF) begin
                store_errors++;
                report_mismatch("data_sram_wen_o", word_t'(wen), 32'hF);
            end
        end
    endtask

    task automatic check_fetch(input word_t got, input word_t expected);
        if (got !== expected) begin
            other_errors++;
            report_mismatch("inst_sram_addr_o", got, expected);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            if (inst_sram_en || data_sram_en || debug_wb_rf_wen != 4'b0) begin
                other_errors++;
                $display("t=%0t: sram access or debug write while in reset", $time);
            end
        end else begin
            if (!fetch_seen && inst_sram_en) begin
                fetch_seen = 1'b1;
                check_fetch(inst_sram_addr, RESET_PC);
            end
            if (data_sram_en && data_sram_wen != 4'b0) begin
                check_store(data_sram_addr, data_sram_wdata, data_sram_wen);
            end
            if (debug_wb_pc == 32'd0 && debug_wb_rf_wen != 4'b0) begin
                other_errors++;
                $display("t=%0t: debug write from a pipeline bubble", $time);
            end else if (debug_wb_pc != 32'd0 && !trace_done) begin
                check_wb(debug_wb_pc, debug_wb_rf_wen, debug_wb_rf_wnum, debug_wb_rf_wdata);
            end
        end
    end

    initial begin
        arst_n          = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        inst_addr_q     = RESET_PC;
        data_addr_q     = '0;
        wb_errors       = 0;
        store_errors    = 0;
        other_errors    = 0;
        trace_done      = 1'b0;
        fetch_seen      = 1'b0;
        for (int k = 0; k < DATA_WORDS; k++) begin
            dmem[k] = fill_word(k);
        end
        generate_program();
        run_model();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        wait (trace_done);
        repeat (4) @(negedge clk);
        if (exp_stores.size() != 0) begin
            other_errors++;
            $display("%0d expected stores never reached the data sram", exp_stores.size());
        end
        $display("errors: trace %0d, store %0d, other %0d", wb_errors, store_errors, other_errors);
        if (wb_errors + store_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TIMEOUT_CYCLES));
        $display("watchdog: writeback trace did not finish, %0d entries still expected",
                 exp_trace.size());
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+testbench
rtl/cpu_pkg.sv
rtl/stage_reg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/alu.sv
rtl/mycpu_top.sv
testbench/tb_top.sv
